//--- vlog.f
st_pkg.sv
st_reset_seq.sv
st_rtc.sv
st_mem_map.sv
st_audio_mix.sv
st_glue_top.sv
tb_st_glue.sv

//--- Bender.yml
package:
  name: st_glue

sources:
  - files:
      - st_pkg.sv
      - st_reset_seq.sv
      - st_rtc.sv
      - st_mem_map.sv
      - st_audio_mix.sv
      - st_glue_top.sv
  - target: test
    files:
      - tb_st_glue.sv

//--- tb_st_glue.sv
// --------------------
// testbench for the system glue top level
// reference models, LFSR stimulus, compare tasks
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_st_glue;

	import st_pkg::*;

	// the run is cut off at twice the planned test length
	localparam int TEST_CYCLES    = 1500;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic        clk_32          = 1'b0;
	logic        xsint           = 1'b0;
	ctrl_word_t  system_ctrl_i   = '0;
	logic        cpu_reset_n_i   = 1'b1;
	rtc_time_t   rtc_i           = '0;
	logic        rtccs_n_i       = 1'b1;
	logic        rtcwr_n_i       = 1'b1;
	nibble_t     rtc_a_i         = '0;
	nibble_t     rtc_wdata_i     = '0;
	addr_t       ram_a_i         = '0;
	addr_t       bus_a_i         = '0;
	logic        rom2_n_i        = 1'b1;
	logic        data_download_i = 1'b0;
	addr_t       data_addr_i     = '0;
	ym_sample_t  ym_l_i          = '0;
	ym_sample_t  ym_r_i          = '0;
	ste_sample_t ste_l_i         = '0;
	ste_sample_t ste_r_i         = '0;
	logic        reset_o;
	logic        peripheral_reset_o;
	logic        mcu_reset_n_o;
	nibble_t     rtc_rdata_o;
	logic        ram_en_o;
	addr_t       rom_a_o;
	mix_sample_t mix_l_o;
	mix_sample_t mix_r_o;

	logic [15:0] lfsr_state   = 16'd65;
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count  = 0;
	nibble_t     bank1_model [16];

	st_glue_top st_glue_top_inst (.*);

	always #4 clk_32 = ~clk_32;

	always @(posedge clk_32) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hb400;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
	endtask

	function automatic nibble_t rtc_ref(input rtc_time_t t, input nibble_t a, input logic bank,
			input nibble_t stored);
		int lsb;
		if (t == '0) begin
			return 4'hf;
		end
		case (a)
			4'hd:    return {3'b100, bank};
			4'he:    return 4'h0;
			4'hf:    return 4'hc;
			default: ;
		endcase
		if (bank) begin
			return stored;
		end
		// weekday follows the year in the time word
		lsb = (a == 4'h6) ? 48 : (a < 4'h6) ? 4 * a : 4 * (a - 1);
		if (a == 4'hb) begin
			return t[lsb +: 4] + RTC_YEAR_OFFSET;
		end
		return t[lsb +: 4];
	endfunction

	function automatic logic ram_en_ref(input int size, input logic viking, input logic steroids,
			input addr_t a);
		int   byte_a;
		int   limit;
		logic live;
		logic hit;
		byte_a = {a, 1'b0};
		limit  = (size == 5) ? 'he00000 : ('h80000 << size);
		live   = (viking && size <= 4) || steroids;
		if (steroids) begin
			hit = (byte_a >= 'he80000) && (byte_a < 'hf00000);
		end else begin
			hit = (byte_a >= 'hc00000) && (byte_a < 'hc40000);
		end
		return (byte_a < limit) || (live && hit);
	endfunction

	// 192K TOS at $fc0000, 256K TOS at $e00000
	function automatic addr_t rom_ref(input logic flag, input logic rom2_n, input addr_t a);
		logic [23:0] byte_a;
		if (rom2_n) begin
			return a;
		end
		byte_a = (flag ? 24'hfc0000 : 24'he00000) | {6'd0, a[17:1], 1'b0};
		return byte_a[23:1];
	endfunction

	function automatic mix_sample_t mix_ref(input ym_sample_t ym, input ste_sample_t ste);
		int ys;
		int ss;
		int sum;
		ys  = int'(ym) - 'h200;
		ss  = int'(ste) - 'h80;
		sum = ys * 16 + ((ys & 'h3ff) >> 6) + ss * 64 + ((ss & 'hff) >> 2);
		return sum[14:0];
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_nibble(input string name, input nibble_t got, input nibble_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_mix(input string name, input mix_sample_t got, input mix_sample_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_32);
		#1;
	endtask

	task automatic rtc_write(input nibble_t a, input nibble_t d);
		rtc_a_i     = a;
		rtc_wdata_i = d;
		rtccs_n_i   = 1'b0;
		rtcwr_n_i   = 1'b0;
		next_cycle();
		rtccs_n_i   = 1'b1;
		rtcwr_n_i   = 1'b1;
	endtask

	// one cycle low CPU RESET instruction
	task automatic pulse_cpu_reset();
		cpu_reset_n_i = 1'b0;
		next_cycle();
		check_bit("mcu_reset_n_o", mcu_reset_n_o, 1'b0);
		check_bit("peripheral_reset_o", peripheral_reset_o, 1'b1);
		cpu_reset_n_i = 1'b1;
		next_cycle();
		check_bit("mcu_reset_n_o", mcu_reset_n_o, 1'b1);
		check_bit("peripheral_reset_o", peripheral_reset_o, 1'b0);
	endtask

	// count edges until reset_o drops and watch the chipset pulse on the way
	task automatic expect_reset_release();
		int edges     = 0;
		int lows      = 0;
		int low_first = 0;
		int low_last  = 0;
		while (reset_o) begin
			next_cycle();
			edges++;
			if (!mcu_reset_n_o) begin
				lows++;
				low_last = edges;
				if (low_first == 0) begin
					low_first = edges;
				end
			end
		end
		if (edges != 128) begin
			other_errors++;
			$display("reset_o fell after %0d edges instead of 128", edges);
		end
		if (lows != 3 || low_last - low_first != 2) begin
			other_errors++;
			$display("mcu_reset_n_o was low for %0d cycles instead of one 3 cycle pulse", lows);
		end
		check_bit("peripheral_reset_o", peripheral_reset_o, 1'b1);
		next_cycle();
		check_bit("peripheral_reset_o", peripheral_reset_o, 1'b0);
	endtask

	initial begin
		logic [63:0] rnd;
		logic        tos_flag;
		mix_sample_t exp_l;
		mix_sample_t exp_r;

		repeat (5) next_cycle();
		check_bit("reset_o", reset_o, 1'b1);
		check_mix("mix_l_o", mix_l_o, '0);
		check_mix("mix_r_o", mix_r_o, '0);
		xsint = 1'b1;
		expect_reset_release();
		pulse_cpu_reset();

		// external reset bit held for three cycles
		system_ctrl_i[0] = 1'b1;
		repeat (3) next_cycle();
		check_bit("reset_o", reset_o, 1'b1);
		system_ctrl_i[0] = 1'b0;
		expect_reset_release();

		// time bank reads with an empty last word
		for (int w = 0; w < 16; w++) begin
			take_bits(64, rnd);
			rtc_i = (w == 15) ? '0 : rnd;
			for (int r = 0; r < 16; r++) begin
				rtc_a_i = r;
				#2;
				check_nibble("rtc_rdata_o", rtc_rdata_o, rtc_ref(rtc_i, r, 1'b0, 4'h0));
				next_cycle();
			end
		end

		// scratch nibble writes and bank 1 readback
		rtc_i = rnd | 64'd1;
		for (int r = 0; r < 13; r++) begin
			take_bits(4, rnd);
			bank1_model[r] = rnd[3:0];
			rtc_write(r, rnd[3:0]);
		end
		rtc_write(4'hd, 4'h1);
		for (int r = 0; r < 16; r++) begin
			rtc_a_i = r;
			#2;
			check_nibble("rtc_rdata_o", rtc_rdata_o, rtc_ref(rtc_i, r, 1'b1, bank1_model[r]));
			next_cycle();
		end
		pulse_cpu_reset();
		rtc_a_i = 4'hd;
		#2;
		check_nibble("rtc_rdata_o", rtc_rdata_o, rtc_ref(rtc_i, 4'hd, 1'b0, 4'h0));
		next_cycle();

		// RAM windows for every size, viking and steroids setting
		for (int size = 0; size < 6; size++) begin
			for (int v = 0; v < 4; v++) begin
				system_ctrl_i[3:1] = size;
				system_ctrl_i[28]  = v[0];
				system_ctrl_i[23]  = v[1];
				system_ctrl_i[24]  = v[1];
				for (int n = 0; n < 12; n++) begin
					take_bits(26, rnd);
					ram_a_i = rnd[22:0];
					// steer some addresses near the window edges
					case (rnd[25:23])
						3'd1:    ram_a_i[23:19] = 5'b00000;
						3'd2:    ram_a_i[23:18] = 6'b110000;
						3'd3:    ram_a_i[23:19] = 5'b11101;
						3'd4:    ram_a_i[23:21] = 3'b110;
						default: ;
					endcase
					#2;
					check_bit("ram_en_o", ram_en_o, ram_en_ref(size, v[0], v[1], ram_a_i));
					next_cycle();
				end
			end
		end
		system_ctrl_i = '0;

		// TOS download to high ROM, an unrelated address, then the E region
		tos_flag = 1'b0;
		for (int phase = 0; phase < 4; phase++) begin
			if (phase > 0) begin
				take_bits(23, rnd);
				data_addr_i = rnd[22:0];
				case (phase)
					1:       data_addr_i[23:18] = 6'b111111;
					2:       data_addr_i[23:20] = 4'h0;
					default: data_addr_i[23:20] = 4'he;
				endcase
				data_download_i = 1'b1;
				next_cycle();
				data_download_i = 1'b0;
				tos_flag = (phase == 1 || phase == 2);
			end
			for (int n = 0; n < 8; n++) begin
				take_bits(24, rnd);
				bus_a_i  = rnd[22:0];
				rom2_n_i = rnd[23];
				#2;
				check_addr("rom_a_o", rom_a_o, rom_ref(tos_flag, rom2_n_i, bus_a_i));
				next_cycle();
			end
		end

		// mixer output lags its inputs by one cycle
		for (int n = 0; n <= 150; n++) begin
			if (n > 0) begin
				check_mix("mix_l_o", mix_l_o, exp_l);
				check_mix("mix_r_o", mix_r_o, exp_r);
			end
			take_bits(36, rnd);
			{ym_l_i, ym_r_i, ste_l_i, ste_r_i} = rnd[35:0];
			exp_l = mix_ref(ym_l_i, ste_l_i);
			exp_r = mix_ref(ym_r_i, ste_r_i);
			next_cycle();
		end

		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- st_glue_top.sv
// --------------------
// system glue top level, control word
// decode and the four glue blocks
// --------------------
`timescale 1ns/1ps
`default_nettype none

module st_glue_top (
	input  wire logic                clk_32,
	input  wire logic                xsint,
	input  wire st_pkg::ctrl_word_t  system_ctrl_i,
	input  wire logic                cpu_reset_n_i,
	output logic                     reset_o,
	output logic                     peripheral_reset_o,
	output logic                     mcu_reset_n_o,
	// RTC
	input  wire st_pkg::rtc_time_t   rtc_i,
	input  wire logic                rtccs_n_i,
	input  wire logic                rtcwr_n_i,
	input  wire st_pkg::nibble_t     rtc_a_i,
	input  wire st_pkg::nibble_t     rtc_wdata_i,
	output st_pkg::nibble_t          rtc_rdata_o,
	// memory map
	input  wire st_pkg::addr_t       ram_a_i,
	output logic                     ram_en_o,
	input  wire st_pkg::addr_t       bus_a_i,
	input  wire logic                rom2_n_i,
	input  wire logic                data_download_i,
	input  wire st_pkg::addr_t       data_addr_i,
	output st_pkg::addr_t            rom_a_o,
	// audio
	input  wire st_pkg::ym_sample_t  ym_l_i,
	input  wire st_pkg::ym_sample_t  ym_r_i,
	input  wire st_pkg::ste_sample_t ste_l_i,
	input  wire st_pkg::ste_sample_t ste_r_i,
	output st_pkg::mix_sample_t      mix_l_o,
	output st_pkg::mix_sample_t      mix_r_o
);

	import st_pkg::*;

	logic      ext_reset;
	mem_size_e mem_size;
	logic      viking_en;
	logic      steroids;

	assign ext_reset = system_ctrl_i[CTRL_EXT_RESET];
	assign mem_size  = mem_size_e'(system_ctrl_i[CTRL_MEM_MSB:CTRL_MEM_LSB]);
	assign viking_en = system_ctrl_i[CTRL_VIKING];
	// STe on steroids needs both the STe and Mega STe bits
	assign steroids  = system_ctrl_i[CTRL_STE] & system_ctrl_i[CTRL_MSTE];

	st_reset_seq st_reset_seq_inst (
		.clk_32             (clk_32),
		.xsint              (xsint),
		.ext_reset_i        (ext_reset),
		.cpu_reset_n_i      (cpu_reset_n_i),
		.reset_o            (reset_o),
		.peripheral_reset_o (peripheral_reset_o),
		.mcu_reset_n_o      (mcu_reset_n_o)
	);

	st_rtc st_rtc_inst (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.periph_reset_i (peripheral_reset_o),
		.rtc_i          (rtc_i),
		.rtc_cs_n_i     (rtccs_n_i),
		.rtc_wr_n_i     (rtcwr_n_i),
		.rtc_a_i        (rtc_a_i),
		.rtc_wdata_i    (rtc_wdata_i),
		.rtc_rdata_o    (rtc_rdata_o)
	);

	st_mem_map st_mem_map_inst (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mem_size_i      (mem_size),
		.viking_en_i     (viking_en),
		.steroids_i      (steroids),
		.ram_a_i         (ram_a_i),
		.ram_en_o        (ram_en_o),
		.bus_a_i         (bus_a_i),
		.rom2_n_i        (rom2_n_i),
		.data_download_i (data_download_i),
		.data_addr_i     (data_addr_i),
		.rom_a_o         (rom_a_o)
	);

	st_audio_mix st_audio_mix_inst (
		.clk_32  (clk_32),
		.xsint   (xsint),
		.ym_l_i  (ym_l_i),
		.ym_r_i  (ym_r_i),
		.ste_l_i (ste_l_i),
		.ste_r_i (ste_r_i),
		.mix_l_o (mix_l_o),
		.mix_r_o (mix_r_o)
	);

endmodule

`default_nettype wire

//--- st_audio_mix.sv
// --------------------
// PSG plus DMA sound stereo mixer
// --------------------
`timescale 1ns/1ps
`default_nettype none

module st_audio_mix (
	input  wire logic                clk_32,
	input  wire logic                xsint,
	input  wire st_pkg::ym_sample_t  ym_l_i,
	input  wire st_pkg::ym_sample_t  ym_r_i,
	input  wire st_pkg::ste_sample_t ste_l_i,
	input  wire st_pkg::ste_sample_t ste_r_i,
	output st_pkg::mix_sample_t      mix_l_o,
	output st_pkg::mix_sample_t      mix_r_o
);

	import st_pkg::*;

	// one output channel, both sources scaled to 15 bits and summed
	function automatic mix_sample_t mix_channel(input ym_sample_t ym, input ste_sample_t ste);
		ym_sample_t  ym_s;
		ste_sample_t ste_s;
		mix_sample_t ym_w;
		mix_sample_t ste_w;
		ym_s  = ym - YM_MIDPOINT;
		ste_s = ste - STE_MIDPOINT;
		// repeat the top bits below to fill the full range
		ym_w  = {ym_s[9], ym_s, ym_s[9:6]};
		ste_w = {ste_s[7], ste_s, ste_s[7:2]};
		return ym_w + ste_w;
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= mix_channel(ym_l_i, ste_l_i);
			mix_r_o <= mix_channel(ym_r_i, ste_r_i);
		end
	end

endmodule

`default_nettype wire

//--- st_mem_map.sv
// --------------------
// RAM enable windows, TOS size detection
// and ROM address remap
// --------------------
`timescale 1ns/1ps
`default_nettype none

module st_mem_map (
	input  wire logic              clk_32,
	input  wire logic              xsint,
	input  wire st_pkg::mem_size_e mem_size_i,
	input  wire logic              viking_en_i,
	input  wire logic              steroids_i,
	input  wire st_pkg::addr_t     ram_a_i,
	output logic                   ram_en_o,
	input  wire st_pkg::addr_t     bus_a_i,
	input  wire logic              rom2_n_i,
	input  wire logic              data_download_i,
	input  wire st_pkg::addr_t     data_addr_i,
	output st_pkg::addr_t          rom_a_o
);

	import st_pkg::*;

	logic size_en;
	logic viking_mem_ok;
	logic viking_live;
	logic viking_hit;
	logic tos192k;

	always_comb begin
		case (mem_size_i)
			MEM_512K: size_en = (ram_a_i[23:19] == 5'b00000);
			MEM_1M:   size_en = (ram_a_i[23:20] == 4'b0000);
			MEM_2M:   size_en = (ram_a_i[23:21] == 3'b000);
			MEM_4M:   size_en = (ram_a_i[23:22] == 2'b00);
			MEM_8M:   size_en = ~ram_a_i[23];
			// everything but the top 2M of the address space
			MEM_14M:  size_en = (ram_a_i[23:21] != 3'b111);
			default:  size_en = 1'b0;
		endcase
	end

	// viking needs 8M or less, unless in steroids mode
	assign viking_mem_ok = (mem_size_i == MEM_512K) || (mem_size_i == MEM_1M) ||
	                       (mem_size_i == MEM_2M) || (mem_size_i == MEM_4M) ||
	                       (mem_size_i == MEM_8M);
	assign viking_live = (viking_en_i && viking_mem_ok) || steroids_i;

	always_comb begin
		if (steroids_i) begin
			viking_hit = (ram_a_i[23:19] == VIKING_WIN_HIGH);
		end else begin
			viking_hit = (ram_a_i[23:18] == VIKING_WIN_LOW);
		end
	end

	assign ram_en_o = size_en | (viking_live & viking_hit);

	// 192K TOS loads at $fc0000, 256K TOS at $e00000
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (data_download_i) begin
			if (data_addr_i[23:18] == 6'b111111) begin
				tos192k <= 1'b1;
			end else if (data_addr_i[23:20] == 4'he) begin
				tos192k <= 1'b0;
			end
		end
	end

	always_comb begin
		if (rom2_n_i) begin
			rom_a_o = bus_a_i;
		end else if (tos192k) begin
			rom_a_o = {TOS_HIGH_BASE, 2'b11, bus_a_i[17:1]};
		end else begin
			rom_a_o = {TOS_LOW_BASE, 2'b00, bus_a_i[17:1]};
		end
	end

endmodule

`default_nettype wire

//--- st_rtc.sv
// --------------------
// RP5C15 real-time clock, register read
// mux and bank 1 nibble storage
// --------------------
`timescale 1ns/1ps
`default_nettype none

module st_rtc (
	input  wire logic               clk_32,
	input  wire logic               xsint,
	input  wire logic               periph_reset_i,
	input  wire st_pkg::rtc_time_t  rtc_i,
	input  wire logic               rtc_cs_n_i,
	input  wire logic               rtc_wr_n_i,
	input  wire st_pkg::nibble_t    rtc_a_i,
	input  wire st_pkg::nibble_t    rtc_wdata_i,
	output st_pkg::nibble_t         rtc_rdata_o
);

	import st_pkg::*;

	logic    rtc_bank;
	logic    rtc_we;
	nibble_t bank0_rdata;
	nibble_t bank1_mem [16];

	assign rtc_we = ~(rtc_cs_n_i | rtc_wr_n_i);

	// time bank straight from the IO controller word
	always_comb begin
		case (rtc_a_i)
			4'h0:    bank0_rdata = rtc_i[3:0];
			4'h1:    bank0_rdata = rtc_i[7:4];
			4'h2:    bank0_rdata = rtc_i[11:8];
			4'h3:    bank0_rdata = rtc_i[15:12];
			4'h4:    bank0_rdata = rtc_i[19:16];
			4'h5:    bank0_rdata = rtc_i[23:20];
			4'h6:    bank0_rdata = rtc_i[51:48];
			4'h7:    bank0_rdata = rtc_i[27:24];
			4'h8:    bank0_rdata = rtc_i[31:28];
			4'h9:    bank0_rdata = rtc_i[35:32];
			4'ha:    bank0_rdata = rtc_i[39:36];
			4'hb:    bank0_rdata = rtc_i[43:40] + RTC_YEAR_OFFSET;
			4'hc:    bank0_rdata = rtc_i[47:44];
			default: bank0_rdata = 4'hf;
		endcase
	end

	always_comb begin
		case (rtc_a_i)
			// mode register shows the bank bit
			4'hd:    rtc_rdata_o = {1'b1, 2'b00, rtc_bank};
			4'he:    rtc_rdata_o = 4'h0;
			4'hf:    rtc_rdata_o = 4'hc;
			default: begin
				if (rtc_bank) begin
					rtc_rdata_o = bank1_mem[rtc_a_i];
				end else begin
					rtc_rdata_o = bank0_rdata;
				end
			end
		endcase
		// no time from the IO controller, so the clock stays invisible
		if (rtc_i == '0) begin
			rtc_rdata_o = 4'hf;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			rtc_bank <= 1'b0;
		end else if (periph_reset_i) begin
			rtc_bank <= 1'b0;
		end else if (rtc_we && rtc_a_i == 4'hd) begin
			rtc_bank <= rtc_wdata_i[0];
		end
	end

	// scratch nibbles
	always_ff @(posedge clk_32) begin
		if (rtc_we && !periph_reset_i && rtc_a_i != 4'hd) begin
			bank1_mem[rtc_a_i] <= rtc_wdata_i;
		end
	end

endmodule

`default_nettype wire

//--- st_reset_seq.sv
// --------------------
// power-on reset counter, peripheral reset
// and short chipset reset pulse
// --------------------
`timescale 1ns/1ps
`default_nettype none

module st_reset_seq (
	input  wire logic clk_32,
	input  wire logic xsint,
	input  wire logic ext_reset_i,
	input  wire logic cpu_reset_n_i,
	output logic      reset_o,
	output logic      peripheral_reset_o,
	output logic      mcu_reset_n_o
);

	import st_pkg::*;

	rst_cnt_t reset_cnt;
	logic     cpu_reset_n_d;
	logic     cpu_reset_fall;

	// RESET instruction from the cpu
	assign cpu_reset_fall = ~cpu_reset_n_i & cpu_reset_n_d;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_cnt          <= RESET_COUNT;
			cpu_reset_n_d      <= 1'b1;
			reset_o            <= 1'b1;
			peripheral_reset_o <= 1'b1;
			mcu_reset_n_o      <= 1'b1;
		end else begin
			cpu_reset_n_d      <= cpu_reset_n_i;
			reset_o            <= (reset_cnt != '0);
			peripheral_reset_o <= reset_o | ~cpu_reset_n_i;

			if (ext_reset_i) begin
				reset_cnt <= RESET_COUNT;
			end else if (reset_cnt != '0) begin
				reset_cnt <= reset_cnt - 1'b1;
			end

			// the memory controller needs the chipset running,
			// so it only sees a short pulse near the end
			if (cpu_reset_fall && reset_cnt == '0) begin
				mcu_reset_n_o <= 1'b0;
			end else if (reset_cnt == MCU_RESET_START) begin
				mcu_reset_n_o <= 1'b0;
			end else if (reset_cnt < MCU_RESET_END) begin
				mcu_reset_n_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- st_pkg.sv
// --------------------
// shared widths, memory-size encoding and
// address constants of the system glue
// --------------------
`default_nettype none

package st_pkg;

	// bus word address, bits 23 down to 1
	typedef logic [23:1] addr_t;
	typedef logic [3:0]  nibble_t;
	// packed BCD time from the IO controller
	typedef logic [63:0] rtc_time_t;
	typedef logic [31:0] ctrl_word_t;
	typedef logic [9:0]  ym_sample_t;
	typedef logic [7:0]  ste_sample_t;
	typedef logic [14:0] mix_sample_t;
	typedef logic [6:0]  rst_cnt_t;

	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// control word fields
	localparam int CTRL_EXT_RESET = 0;
	localparam int CTRL_MEM_LSB   = 1;
	localparam int CTRL_MEM_MSB   = 3;
	localparam int CTRL_STE       = 23;
	localparam int CTRL_MSTE      = 24;
	localparam int CTRL_VIKING    = 28;

	// reset sequencer
	localparam rst_cnt_t RESET_COUNT     = 7'd127;
	localparam rst_cnt_t MCU_RESET_START = 7'd10;
	localparam rst_cnt_t MCU_RESET_END   = 7'd8;

	// GEMDOS counts years from 1980
	localparam nibble_t RTC_YEAR_OFFSET = 4'd2;

	// viking video memory at $c00000 or $e80000
	localparam logic [5:0] VIKING_WIN_LOW  = 6'b110000;
	localparam logic [4:0] VIKING_WIN_HIGH = 5'b11101;

	// rom remap bases for 256K and 192K TOS
	localparam nibble_t TOS_LOW_BASE  = 4'he;
	localparam nibble_t TOS_HIGH_BASE = 4'hf;

	// midpoint of the unsigned audio samples
	localparam ym_sample_t  YM_MIDPOINT  = 10'h200;
	localparam ste_sample_t STE_MIDPOINT = 8'h80;

endpackage

`default_nettype wire
